/* mmc2_mapper.f */
+incdir+src
src/mmc2_pkg.sv
src/mmc2_bank_regs.sv
src/mmc2_chr_latch.sv
src/mmc2_prg_stage.sv
src/mmc2_chr_stage.sv
src/mmc2_mapper.sv
testbench/mmc2_properties.sv
testbench/mmc2_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mmc2_tb
FILELIST  := mmc2_mapper.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/mmc2_tb.sv */
`timescale 1ns/1ps

`include "mmc2_defs.svh"

module mmc2_tb import mmc2_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20;
	localparam int ROUNDS         = 48;

	logic                    mai;
	logic                    rst_n;
	mapper_kind_t            kind;
	logic                    cpu_we;
	logic                    cpu_rd;
	logic [15:0]             cpu_addr;
	logic [7:0]              cpu_data;
	logic                    ppu_rd;
	logic [13:0]             ppu_addr;
	logic                    sst_act;
	logic                    sst_we;
	logic [7:0]              sst_addr;
	logic [7:0]              sst_wdata;
	logic                    prg_valid;
	logic [`MMC2_PRG_AW-1:0] prg_addr;
	logic                    prg_ce;
	logic                    chr_valid;
	logic [`MMC2_CHR_AW-1:0] chr_addr;
	logic                    ciram_ce;
	logic                    ciram_a10;
	logic [7:0]              sst_rdata;

	prg_bank_t   m_prg; // Reference model of the mapper registers
	chr_bank_t   m_chr [4];
	mirror_t     m_mirror;
	logic        m_latch0;
	logic        m_latch1;
	logic [31:0] lfsr;
	int          checks;
	int          errors;
	int          test_errors; // Error count when the running test started

	mmc2_mapper u_mmc2_mapper (.*);

	initial begin
		mai = 1'b0;
		forever #5 mai = ~mai;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit taken
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Half the fetches hit a latch trigger on the high bitplane
	function automatic logic [13:0] pick_fetch();
		if (rand_bits(1) == 32'd0) begin
			return 14'(rand_bits(13));
		end
		return {1'b0, 1'(rand_bits(1)), (rand_bits(1) == 32'd1) ? 8'hfe : 8'hfd, 4'h8};
	endfunction

	function automatic logic [7:0] pick_index();
		logic [2:0] sel;
		sel = 3'(rand_bits(3));
		if (sel <= 3'd5) begin
			return 8'(sel);
		end
		return (rand_bits(1) == 32'd1) ? `MMC2_SST_KIND : 8'(rand_bits(8));
	endfunction

	function automatic logic [`MMC2_PRG_AW-1:0] exp_prg_addr(input logic [15:0] a);
		logic [4:0] page;
		if (kind == MAP_MMC4) begin
			return {a[14] ? 4'hf : m_prg, a[13:0]}; // $C000 holds the last 16 KiB bank
		end
		case (a[14:13])
			2'd0:    page = {1'b0, m_prg};
			2'd1:    page = 5'd13;
			2'd2:    page = 5'd14;
			default: page = 5'd15;
		endcase
		return {page, a[12:0]};
	endfunction

	function automatic logic [`MMC2_CHR_AW-1:0] exp_chr_addr(input logic [13:0] a);
		chr_bank_t bank;
		if (a[12]) begin
			bank = m_latch1 ? m_chr[3] : m_chr[2];
		end else begin
			bank = m_latch0 ? m_chr[1] : m_chr[0];
		end
		return {bank, a[11:0]};
	endfunction

	function automatic logic [7:0] exp_sst(input logic [7:0] idx);
		case (idx)
			`MMC2_SST_PRG:  return {4'd0, m_prg};
			`MMC2_SST_CHR0, `MMC2_SST_CHR1, `MMC2_SST_CHR2, `MMC2_SST_CHR3:
				return {3'd0, m_chr[idx[1:0] - 2'd1]};
			`MMC2_SST_CTRL: return {5'd0, m_latch1, m_latch0, m_mirror};
			`MMC2_SST_KIND: return (kind == MAP_MMC4) ? 8'd10 : 8'd9;
			default:        return 8'hff;
		endcase
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if (sst_act || !a[15]) return;
		case (a[14:12])
			3'd2:    m_prg = d[3:0];
			3'd3:    m_chr[0] = d[4:0];
			3'd4:    m_chr[1] = d[4:0];
			3'd5:    m_chr[2] = d[4:0];
			3'd6:    m_chr[3] = d[4:0];
			3'd7:    m_mirror = mirror_t'(d[0]);
			default: ;
		endcase
	endtask

	task automatic model_load(input logic [7:0] idx, input logic [7:0] d);
		case (idx)
			`MMC2_SST_PRG:  m_prg = d[3:0];
			`MMC2_SST_CHR0: m_chr[0] = d[4:0];
			`MMC2_SST_CHR1: m_chr[1] = d[4:0];
			`MMC2_SST_CHR2: m_chr[2] = d[4:0];
			`MMC2_SST_CHR3: m_chr[3] = d[4:0];
			`MMC2_SST_CTRL: begin
				m_mirror = mirror_t'(d[0]);
				m_latch0 = d[1];
				m_latch1 = d[2];
			end
			default: ;
		endcase
	endtask

	task automatic model_fetch(input logic [13:0] a);
		if (sst_act || !a[3]) return;
		case (a[13:4])
			10'h0fd: m_latch0 = 1'b0;
			10'h0fe: m_latch0 = 1'b1;
			10'h1fd: m_latch1 = 1'b0;
			10'h1fe: m_latch1 = 1'b1;
			default: ;
		endcase
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	task automatic wait_valid(input bit chr_side, output bit seen);
		int n;
		n = 0;
		while (!(chr_side ? chr_valid : prg_valid) && n < TIMEOUT_CYCLES) begin
			@(negedge mai);
			n++;
		end
		seen = chr_side ? chr_valid : prg_valid;
		if (!seen) begin
			errors++;
			$display("Timeout at %0t ns: the %s pulse never came after its read strobe",
				$time, chr_side ? "chr_valid" : "prg_valid");
		end
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_we   = 1'b1;
		cpu_addr = a;
		cpu_data = d;
		@(negedge mai);
		cpu_we = 1'b0;
		model_write(a, d);
	endtask

	task automatic cpu_read(input logic [15:0] a);
		logic [`MMC2_PRG_AW-1:0] want;
		bit                      seen;
		want     = exp_prg_addr(a);
		cpu_rd   = 1'b1;
		cpu_addr = a;
		@(negedge mai);
		cpu_rd = 1'b0;
		wait_valid(1'b0, seen);
		if (seen) begin
			check_value("prg_addr", 32'(prg_addr), 32'(want));
			check_value("prg_ce", 32'(prg_ce), 32'(a[15]));
		end
	endtask

	task automatic ppu_fetch(input logic [13:0] a);
		logic [`MMC2_CHR_AW-1:0] want;
		logic                    want_a10;
		bit                      seen;
		want     = exp_chr_addr(a); // Latch state from before this fetch
		want_a10 = (m_mirror == MIR_HORZ) ? a[11] : a[10];
		ppu_rd   = 1'b1;
		ppu_addr = a;
		@(negedge mai);
		ppu_rd = 1'b0;
		wait_valid(1'b1, seen);
		if (seen) begin
			check_value("chr_addr", 32'(chr_addr), 32'(want));
			check_value("ciram_ce", 32'(ciram_ce), 32'(a[13]));
			check_value("ciram_a10", 32'(ciram_a10), 32'(want_a10));
		end
		model_fetch(a);
	endtask

	task automatic sst_load(input logic [7:0] idx, input logic [7:0] d);
		sst_we    = 1'b1;
		sst_addr  = idx;
		sst_wdata = d;
		@(negedge mai);
		sst_we = 1'b0;
		model_load(idx, d);
	endtask

	task automatic sst_check(input logic [7:0] idx);
		sst_addr = idx;
		#2; // Readback is combinational
		check_value("sst_rdata", 32'(sst_rdata), 32'(exp_sst(idx)));
		@(negedge mai);
	endtask

	task automatic end_test(input string name);
		$display("%-7s %-16s checks so far %0d, new errors %0d",
			(errors == test_errors) ? "done" : "failed", name, checks, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		rst_n     = 1'b0;
		kind      = MAP_MMC2;
		cpu_we    = 1'b0;
		cpu_rd    = 1'b1; // Read strobes during reset must not raise a valid output
		cpu_addr  = '0;
		cpu_data  = '0;
		ppu_rd    = 1'b1;
		ppu_addr  = '0;
		sst_act   = 1'b0;
		sst_we    = 1'b0;
		sst_addr  = '0;
		sst_wdata = '0;
		m_prg     = '0;
		m_chr     = '{default: '0};
		m_mirror  = MIR_VERT;
		m_latch0  = 1'b0;
		m_latch1  = 1'b0;
		lfsr        = 32'd96931;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		repeat (3) @(negedge mai);
		cpu_rd = 1'b0;
		ppu_rd = 1'b0;
		repeat (2) @(negedge mai);
		rst_n = 1'b1;
		@(negedge mai);

		repeat (4) begin
			check_value("prg_valid", 32'(prg_valid), 32'd0);
			check_value("chr_valid", 32'(chr_valid), 32'd0);
			@(negedge mai);
		end
		for (int i = 0; i <= 5; i++) sst_check(8'(i));
		sst_check(`MMC2_SST_KIND);
		end_test("reset state");

		repeat (ROUNDS) begin
			cpu_write(16'h8000 | 16'(rand_bits(15)), 8'(rand_bits(8)));
			cpu_read(16'(rand_bits(16)));
		end
		end_test("mmc2 prg");

		kind = MAP_MMC4;
		repeat (ROUNDS) begin
			cpu_write(16'h8000 | 16'(rand_bits(15)), 8'(rand_bits(8)));
			cpu_read(16'(rand_bits(16)));
		end
		end_test("mmc4 prg");

		repeat (ROUNDS) begin
			cpu_write({4'hb + 4'(rand_bits(2)), 12'h000}, 8'(rand_bits(8))); // CHR banks only
			repeat (4) ppu_fetch(pick_fetch());
		end
		end_test("chr latches");

		repeat (ROUNDS) begin
			cpu_write(16'hf000 | 16'(rand_bits(12)), 8'(rand_bits(8)));
			repeat (3) ppu_fetch(14'h2000 | 14'(rand_bits(13)));
		end
		end_test("mirroring");

		sst_act = 1'b1;
		repeat (ROUNDS) begin
			sst_load(pick_index(), 8'(rand_bits(8)));
			cpu_write(16'h8000 | 16'(rand_bits(15)), 8'(rand_bits(8)));
			ppu_fetch(pick_fetch());
		end
		sst_check(`MMC2_SST_KIND);
		kind = mapper_kind_t'(rand_bits(1));
		for (int i = 0; i <= 5; i++) sst_check(8'(i));
		sst_check(`MMC2_SST_KIND);
		sst_check(8'd6 + 8'(rand_bits(7)));
		sst_act = 1'b0;
		repeat (8) begin
			ppu_fetch(pick_fetch());
			cpu_read(16'h8000 | 16'(rand_bits(15)));
		end
		end_test("save state");

		errors += u_mmc2_mapper.u_props.fail_count;
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* testbench/mmc2_properties.sv */
`timescale 1ns/1ps

module mmc2_properties (
	input logic mai,
	input logic rst_n,
	input logic cpu_rd,
	input logic ppu_rd,
	input logic prg_valid,
	input logic chr_valid,
	input logic sst_act,
	input logic ctrl_load,
	input logic latch0,
	input logic latch1
);

	int fail_count = 0; // Read by the testbench at the end of the run

	prg_latency: assert property (@(posedge mai) disable iff (!rst_n) prg_valid == $past(cpu_rd))
		else begin
			$error("prg_valid does not follow cpu_rd by exactly one cycle");
			fail_count++;
		end

	chr_latency: assert property (@(posedge mai) disable iff (!rst_n) chr_valid == $past(ppu_rd))
		else begin
			$error("chr_valid does not follow ppu_rd by exactly one cycle");
			fail_count++;
		end

	quiet_in_reset: assert property (@(posedge mai) !rst_n |-> (!prg_valid && !chr_valid))
		else begin
			$error("a valid output is high during reset");
			fail_count++;
		end

	// Save-state mode freezes the tile latches unless the control word is reloaded
	latch_frozen: assert property (@(posedge mai) disable iff (!rst_n)
		(sst_act && !ctrl_load) |=> (latch0 == $past(latch0) && latch1 == $past(latch1)))
		else begin
			$error("a tile latch changed in save-state mode without a control load");
			fail_count++;
		end

endmodule

bind mmc2_mapper mmc2_properties u_props (
	.mai(mai), .rst_n(rst_n), .cpu_rd(cpu_rd), .ppu_rd(ppu_rd),
	.prg_valid(prg_valid), .chr_valid(chr_valid), .sst_act(sst_act),
	.ctrl_load(ctrl_load), .latch0(latch0), .latch1(latch1)
);

/* src/mmc2_mapper.sv */
`timescale 1ns/1ps

`include "mmc2_defs.svh"

module mmc2_mapper import mmc2_pkg::*; (
	input  logic                    mai,
	input  logic                    rst_n,
	input  mapper_kind_t            kind,
	input  logic                    cpu_we,
	input  logic                    cpu_rd,
	input  cpu_addr_t               cpu_addr,
	input  logic [7:0]              cpu_data,
	input  logic                    ppu_rd,
	input  ppu_addr_t               ppu_addr,
	input  logic                    sst_act,
	input  logic                    sst_we,
	input  logic [7:0]              sst_addr,
	input  logic [7:0]              sst_wdata,
	output logic                    prg_valid,
	output logic [`MMC2_PRG_AW-1:0] prg_addr,
	output logic                    prg_ce,
	output logic                    chr_valid,
	output logic [`MMC2_CHR_AW-1:0] chr_addr,
	output logic                    ciram_ce,
	output logic                    ciram_a10,
	output logic [7:0]              sst_rdata
);

	prg_bank_t  prg_bank;
	chr_bank_t  chr_bank0;
	chr_bank_t  chr_bank1;
	chr_bank_t  chr_bank2;
	chr_bank_t  chr_bank3;
	mirror_t    mirror;
	logic       latch0;
	logic       latch1;
	logic       ctrl_load; // Save-state restore of mirroring and latches
	logic [7:0] ctrl_data;

	mmc2_bank_regs u_bank_regs (
		.mai(mai), .rst_n(rst_n), .kind(kind),
		.cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_data(cpu_data),
		.sst_act(sst_act), .sst_we(sst_we), .sst_addr(sst_addr), .sst_wdata(sst_wdata),
		.latch0(latch0), .latch1(latch1),
		.prg_bank(prg_bank),
		.chr_bank0(chr_bank0), .chr_bank1(chr_bank1),
		.chr_bank2(chr_bank2), .chr_bank3(chr_bank3),
		.mirror(mirror), .ctrl_load(ctrl_load), .ctrl_data(ctrl_data),
		.sst_rdata(sst_rdata)
	);

	mmc2_chr_latch u_chr_latch (
		.mai(mai), .rst_n(rst_n), .sst_act(sst_act),
		.ctrl_load(ctrl_load), .ctrl_data(ctrl_data),
		.ppu_rd(ppu_rd), .ppu_addr(ppu_addr),
		.latch0(latch0), .latch1(latch1)
	);

	mmc2_prg_stage u_prg_stage (
		.mai(mai), .rst_n(rst_n), .kind(kind), .prg_bank(prg_bank),
		.cpu_rd(cpu_rd), .cpu_addr(cpu_addr),
		.prg_valid(prg_valid), .prg_addr(prg_addr), .prg_ce(prg_ce)
	);

	mmc2_chr_stage u_chr_stage (
		.mai(mai), .rst_n(rst_n),
		.chr_bank0(chr_bank0), .chr_bank1(chr_bank1),
		.chr_bank2(chr_bank2), .chr_bank3(chr_bank3),
		.latch0(latch0), .latch1(latch1), .mirror(mirror),
		.ppu_rd(ppu_rd), .ppu_addr(ppu_addr),
		.chr_valid(chr_valid), .chr_addr(chr_addr),
		.ciram_ce(ciram_ce), .ciram_a10(ciram_a10)
	);

endmodule

/* src/mmc2_chr_stage.sv */
`timescale 1ns/1ps

`include "mmc2_defs.svh"

module mmc2_chr_stage import mmc2_pkg::*; (
	input  logic                    mai,
	input  logic                    rst_n,
	input  chr_bank_t               chr_bank0,
	input  chr_bank_t               chr_bank1,
	input  chr_bank_t               chr_bank2,
	input  chr_bank_t               chr_bank3,
	input  logic                    latch0,
	input  logic                    latch1,
	input  mirror_t                 mirror,
	input  logic                    ppu_rd,
	input  ppu_addr_t               ppu_addr,
	output logic                    chr_valid,
	output logic [`MMC2_CHR_AW-1:0] chr_addr,
	output logic                    ciram_ce,
	output logic                    ciram_a10
);

	chr_bank_t lo_bank;
	chr_bank_t hi_bank;
	chr_bank_t bank;
	logic      nt_a10;

	// Each pattern table half has its own latch and bank pair
	assign lo_bank = latch0 ? chr_bank1 : chr_bank0;
	assign hi_bank = latch1 ? chr_bank3 : chr_bank2;
	assign bank    = ppu_addr[12] ? hi_bank : lo_bank;

	// Vertical mirroring splits the nametables on A10, horizontal on A11
	assign nt_a10 = (mirror == MIR_VERT) ? ppu_addr[10] : ppu_addr[11];

	always_ff @(posedge mai or negedge rst_n) begin
		if (!rst_n) begin
			chr_valid <= 1'b0;
		end else begin
			chr_valid <= ppu_rd;
		end
	end

	always_ff @(posedge mai) begin
		if (ppu_rd) begin
			chr_addr  <= {bank, ppu_addr[`MMC2_CHR_WIN_AW-1:0]};
			ciram_ce  <= ppu_addr[13]; // Nametable space from $2000
			ciram_a10 <= nt_a10;
		end
	end

endmodule

/* src/mmc2_prg_stage.sv */
`timescale 1ns/1ps

`include "mmc2_defs.svh"

module mmc2_prg_stage import mmc2_pkg::*; (
	input  logic                    mai,
	input  logic                    rst_n,
	input  mapper_kind_t            kind,
	input  prg_bank_t               prg_bank,
	input  logic                    cpu_rd,
	input  cpu_addr_t               cpu_addr,
	output logic                    prg_valid,
	output logic [`MMC2_PRG_AW-1:0] prg_addr,
	output logic                    prg_ce
);

	localparam int WIN_W = `MMC2_PRG_AW - `MMC2_PRG_WIN_AW;

	logic [WIN_W-1:0] win_mmc2; // 8 KiB page number, address bits 17 to 13
	logic [WIN_W-1:0] win_mmc4;
	logic [WIN_W-1:0] win;

	// Pages 13 to 15 sit behind $A000, $C000 and $E000
	assign win_mmc2 = (cpu_addr[14:13] == 2'b00) ? {1'b0, prg_bank}
	                                             : {3'b011, cpu_addr[14:13]};

	// The 16 KiB bank number lands above A13, which passes through
	assign win_mmc4 = !cpu_addr[14] ? {prg_bank, cpu_addr[13]}
	                                : {4'b1111, cpu_addr[13]};

	assign win = (kind == MAP_MMC4) ? win_mmc4 : win_mmc2;

	always_ff @(posedge mai or negedge rst_n) begin
		if (!rst_n) begin
			prg_valid <= 1'b0;
		end else begin
			prg_valid <= cpu_rd;
		end
	end

	always_ff @(posedge mai) begin
		if (cpu_rd) begin
			prg_addr <= {win, cpu_addr[`MMC2_PRG_WIN_AW-1:0]};
			prg_ce   <= cpu_addr[15]; // ROM answers $8000 to $FFFF
		end
	end

endmodule

/* src/mmc2_chr_latch.sv */
`timescale 1ns/1ps

module mmc2_chr_latch import mmc2_pkg::*; (
	input  logic       mai,
	input  logic       rst_n,
	input  logic       sst_act,
	input  logic       ctrl_load,
	input  logic [7:0] ctrl_data,
	input  logic       ppu_rd,
	input  ppu_addr_t  ppu_addr,
	output logic       latch0,
	output logic       latch1
);

	logic       hi_plane;
	logic [9:0] tile;   // Pattern table half and tile number, address bits 13 to 4
	logic       clr0;
	logic       set0;
	logic       clr1;
	logic       set1;

	// Only the high bitplane fetch of tiles $FD and $FE triggers
	assign hi_plane = ppu_rd & ppu_addr[3];
	assign tile     = ppu_addr[13:4];

	always_comb begin
		clr0 = 1'b0;
		set0 = 1'b0;
		clr1 = 1'b0;
		set1 = 1'b0;
		if (hi_plane) begin
			case (tile)
				10'h0fd: clr0 = 1'b1; // Left table, tile $FD
				10'h0fe: set0 = 1'b1;
				10'h1fd: clr1 = 1'b1; // Right table, tile $FD
				10'h1fe: set1 = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge mai or negedge rst_n) begin
		if (!rst_n) begin
			latch0 <= 1'b0;
			latch1 <= 1'b0;
		end else if (sst_act) begin
			// PPU fetches are ignored while a state is being saved or loaded
			if (ctrl_load) begin
				latch0 <= ctrl_data[1];
				latch1 <= ctrl_data[2];
			end
		end else begin
			if (clr0) latch0 <= 1'b0;
			if (set0) latch0 <= 1'b1;
			if (clr1) latch1 <= 1'b0;
			if (set1) latch1 <= 1'b1;
		end
	end

endmodule

/* src/mmc2_bank_regs.sv */
`timescale 1ns/1ps

`include "mmc2_defs.svh"

module mmc2_bank_regs import mmc2_pkg::*; (
	input  logic         mai,
	input  logic         rst_n,
	input  mapper_kind_t kind,
	input  logic         cpu_we,
	input  cpu_addr_t    cpu_addr,
	input  logic [7:0]   cpu_data,
	input  logic         sst_act,
	input  logic         sst_we,
	input  logic [7:0]   sst_addr,
	input  logic [7:0]   sst_wdata,
	input  logic         latch0,
	input  logic         latch1,
	output prg_bank_t    prg_bank,
	output chr_bank_t    chr_bank0,
	output chr_bank_t    chr_bank1,
	output chr_bank_t    chr_bank2,
	output chr_bank_t    chr_bank3,
	output mirror_t      mirror,
	output logic         ctrl_load,
	output logic [7:0]   ctrl_data,
	output logic [7:0]   sst_rdata
);

	logic       wr_prg;
	logic [3:0] wr_chr; // One enable per CHR bank register
	logic       wr_ctrl;
	logic [7:0] wr_data;

	// CPU writes and save-state loads share one write path
	always_comb begin
		wr_prg  = 1'b0;
		wr_chr  = 4'b0000;
		wr_ctrl = 1'b0;
		wr_data = sst_act ? sst_wdata : cpu_data;
		if (sst_act) begin
			if (sst_we) begin
				case (sst_addr)
					`MMC2_SST_PRG:  wr_prg    = 1'b1;
					`MMC2_SST_CHR0: wr_chr[0] = 1'b1;
					`MMC2_SST_CHR1: wr_chr[1] = 1'b1;
					`MMC2_SST_CHR2: wr_chr[2] = 1'b1;
					`MMC2_SST_CHR3: wr_chr[3] = 1'b1;
					`MMC2_SST_CTRL: wr_ctrl   = 1'b1;
					default: ;
				endcase
			end
		end else if (cpu_we && cpu_addr[15]) begin
			case (cpu_addr[14:12]) // $A000 to $F000 in 4 KiB steps
				3'd2: wr_prg    = 1'b1;
				3'd3: wr_chr[0] = 1'b1;
				3'd4: wr_chr[1] = 1'b1;
				3'd5: wr_chr[2] = 1'b1;
				3'd6: wr_chr[3] = 1'b1;
				3'd7: wr_ctrl   = 1'b1;
				default: ; // $8000 and $9000 have no register
			endcase
		end
	end

	always_ff @(posedge mai or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank  <= '0;
			chr_bank0 <= '0;
			chr_bank1 <= '0;
			chr_bank2 <= '0;
			chr_bank3 <= '0;
			mirror    <= MIR_VERT;
		end else begin
			if (wr_prg)    prg_bank  <= wr_data[3:0];
			if (wr_chr[0]) chr_bank0 <= wr_data[4:0];
			if (wr_chr[1]) chr_bank1 <= wr_data[4:0];
			if (wr_chr[2]) chr_bank2 <= wr_data[4:0];
			if (wr_chr[3]) chr_bank3 <= wr_data[4:0];
			if (wr_ctrl)   mirror    <= mirror_t'(wr_data[0]);
		end
	end

	// Only a save-state load of the control word restores the latches
	assign ctrl_load = sst_act & wr_ctrl;
	assign ctrl_data = wr_data;

	always_comb begin
		case (sst_addr)
			`MMC2_SST_PRG:  sst_rdata = {4'd0, prg_bank};
			`MMC2_SST_CHR0: sst_rdata = {3'd0, chr_bank0};
			`MMC2_SST_CHR1: sst_rdata = {3'd0, chr_bank1};
			`MMC2_SST_CHR2: sst_rdata = {3'd0, chr_bank2};
			`MMC2_SST_CHR3: sst_rdata = {3'd0, chr_bank3};
			`MMC2_SST_CTRL: sst_rdata = {5'd0, latch1, latch0, mirror};
			`MMC2_SST_KIND: sst_rdata = (kind == MAP_MMC4) ? `MMC4_KIND_CODE : `MMC2_KIND_CODE;
			default:        sst_rdata = 8'hff;
		endcase
	end

endmodule

/* src/mmc2_pkg.sv */
package mmc2_pkg;

	// Run-time variant select
	typedef enum logic {
		MAP_MMC2 = 1'b0, // 8 KiB PRG switching, mapper 9
		MAP_MMC4 = 1'b1  // 16 KiB PRG switching, mapper 10
	} mapper_kind_t;

	// Switchable PRG bank number, 8 KiB or 16 KiB units depending on the variant
	typedef logic [3:0] prg_bank_t;

	// CHR bank number in 4 KiB units
	typedef logic [4:0] chr_bank_t;

	// Nametable arrangement
	typedef enum logic {
		MIR_VERT = 1'b0, // CIRAM A10 follows PPU A10
		MIR_HORZ = 1'b1  // CIRAM A10 follows PPU A11
	} mirror_t;

	// CPU and PPU bus addresses
	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;

endpackage

/* src/mmc2_defs.svh */
`ifndef MMC2_DEFS_SVH
`define MMC2_DEFS_SVH

// ROM address widths
`define MMC2_PRG_AW 18 // 256 KiB of PRG, MMC2 stays in the lower half
`define MMC2_CHR_AW 17 // 128 KiB of CHR in 4 KiB banks

// Width of the address bits below one 8 KiB PRG window
`define MMC2_PRG_WIN_AW 13

// Width of the address bits below one 4 KiB CHR bank
`define MMC2_CHR_WIN_AW 12

// Save-state register indices
`define MMC2_SST_PRG  8'd0
`define MMC2_SST_CHR0 8'd1
`define MMC2_SST_CHR1 8'd2
`define MMC2_SST_CHR2 8'd3
`define MMC2_SST_CHR3 8'd4
`define MMC2_SST_CTRL 8'd5  // Mirroring and both tile latches
`define MMC2_SST_KIND 8'd127 // Read-only mapper number

// Mapper numbers reported through the save-state port
`define MMC2_KIND_CODE 8'd9
`define MMC4_KIND_CODE 8'd10

`endif
